// ==== tb.f ====
+incdir+src
src/icache_pkg.sv
src/icache.sv
src/fill_arbiter.sv
src/icache_pair_top.sv
bench/axi_lite_rom.sv
bench/icache_tb.sv

// ==== Makefile ====
TOP := icache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f tb.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// ==== bench/icache_tb.sv ====
`default_nettype none
`include "icache_defines.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int num_reqs    = 400;
    localparam int cycle_limit = num_reqs * 30;

    typedef struct packed {
        word_t data;
        logic  hit;
        logic  err;
        int    edge_no;   // cycle count after the accepting edge
    } expect_t;

    logic       clk = 1'b0;
    logic       reset;
    fetch_req_t req_a;
    fetch_req_t req_b;
    logic       req_ready_a;
    logic       req_ready_b;
    fetch_rsp_t rsp_a;
    fetch_rsp_t rsp_b;
    axi_ar_t    ar;
    logic       arready;
    axi_r_t     r;
    logic       rready;

    int      cycle = 0;
    int      resp_count = 0;
    expect_t exp_a [$];
    expect_t exp_b [$];

    // reference LRU state, one copy per port
    logic m_valid [2][`ICACHE_SETS][`ICACHE_WAYS];
    tag_t m_tag   [2][`ICACHE_SETS][`ICACHE_WAYS];
    age_t m_age   [2][`ICACHE_SETS][`ICACHE_WAYS];

    tag_t   tag_tbl [6] = '{24'h000040, 24'h0013a7, 24'h02f1c0,
                            24'h1000ff, 24'h3abcde, 24'h7f0001};
    index_t idx_tbl [4] = '{6'd5, 6'd17, 6'd38, 6'd63};

    icache_pair_top icache_pair_top_i (
        .clk         (clk),
        .reset       (reset),
        .req_a       (req_a),
        .req_ready_a (req_ready_a),
        .rsp_a       (rsp_a),
        .req_b       (req_b),
        .req_ready_b (req_ready_b),
        .rsp_b       (rsp_b),
        .ar          (ar),
        .arready     (arready),
        .r           (r),
        .rready      (rready)
    );

    axi_lite_rom rom_i (
        .clk     (clk),
        .reset   (reset),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == cycle_limit) begin
            $display("timeout, responses still missing after %0d cycles", cycle_limit);
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            fail_run();
        end
    endtask

    function automatic word_t swapped_halves(input addr_t a);
        return {a[15:0], a[31:16]};
    endfunction

    function automatic addr_t random_addr();
        tag_t   t;
        index_t i;
        t = tag_tbl[int'($urandom % 6)];
        i = idx_tbl[int'($urandom % 4)];
        if ($urandom % 100 < 5) begin
            t[`ICACHE_TAG_W-1] = 1'b1;   // bad address, memory answers SLVERR
        end
        return {t, i, {`ICACHE_OFFSET_W{1'b0}}};
    endfunction

    // all lines invalid, ages 0..3 in way order
    task automatic reset_model();
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    m_valid[p][s][w] = 1'b0;
                    m_age[p][s][w]   = age_t'(w);
                end
            end
        end
    endtask

    // predicts hit or miss and moves the LRU state on
    function automatic logic model_access(input int port, input addr_t a);
        tag_t t;
        int   idx;
        int   way;
        logic hit;
        age_t old;
        t   = a[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        idx = int'(a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]);
        hit = 1'b0;
        way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (m_valid[port][idx][w] && (m_tag[port][idx][w] == t)) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            if (a[`ICACHE_ADDR_W-1]) begin
                return 1'b0;   // failed fill, nothing allocated
            end
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if ((way < 0) && !m_valid[port][idx][w]) begin
                    way = w;
                end
            end
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if ((way < 0) && (m_age[port][idx][w] == age_t'(`ICACHE_WAYS - 1))) begin
                    way = w;
                end
            end
            m_valid[port][idx][way] = 1'b1;
            m_tag[port][idx][way]   = t;
        end
        old = m_age[port][idx][way];
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (w == way) begin
                m_age[port][idx][w] = '0;
            end else if (m_age[port][idx][w] < old) begin
                m_age[port][idx][w] = m_age[port][idx][w] + age_t'(1);
            end
        end
        return hit;
    endfunction

    function automatic logic ready_of(input int port);
        return (port == 0) ? req_ready_a : req_ready_b;
    endfunction

    task automatic set_req(input int port, input logic valid, input addr_t a);
        if (port == 0) begin
            req_a.valid = valid;
            req_a.addr  = a;
        end else begin
            req_b.valid = valid;
            req_b.addr  = a;
        end
    endtask

    task automatic drive_port(input int port);
        addr_t   a;
        expect_t e;
        int      gap;
        for (int n = 0; n < num_reqs; n++) begin
            gap = int'($urandom % 4);
            repeat (gap) @(negedge clk);
            a = random_addr();
            set_req(port, 1'b1, a);
            while (!ready_of(port)) @(negedge clk);
            e.data    = swapped_halves(a);   // accepted at the coming edge
            e.err     = a[`ICACHE_ADDR_W-1];
            e.hit     = model_access(port, a);
            e.edge_no = cycle + 1;
            if (port == 0) begin
                exp_a.push_back(e);
            end else begin
                exp_b.push_back(e);
            end
            @(negedge clk);
            set_req(port, 1'b0, a);
        end
    endtask

    task automatic take_response(input int port, input fetch_rsp_t got);
        expect_t e;
        string   name;
        name = (port == 0) ? "port a" : "port b";
        if ((port == 0) ? (exp_a.size() == 0) : (exp_b.size() == 0)) begin
            $display("response on %s without an accepted request", name);
            fail_run();
        end
        if (port == 0) begin
            e = exp_a.pop_front();
        end else begin
            e = exp_b.pop_front();
        end
        check({name, " data"}, 64'(e.data), 64'(got.data));
        check({name, " hit"}, 64'(e.hit), 64'(got.hit));
        check({name, " err"}, 64'(e.err), 64'(got.err));
        if (e.hit) begin
            check({name, " hit latency"}, 64'(e.edge_no + 1), 64'(cycle));
        end
        resp_count = resp_count + 1;
    endtask

    always @(negedge clk) begin
        if (reset) begin
            if (rsp_a.valid) begin
                take_response(0, rsp_a);
            end
            if (rsp_b.valid) begin
                take_response(1, rsp_b);
            end
        end
    end

    task automatic check_reset_values();
        check("reset req_ready_a", 64'(1'b1), 64'(req_ready_a));
        check("reset req_ready_b", 64'(1'b1), 64'(req_ready_b));
        check("reset rsp_a valid", 64'(1'b0), 64'(rsp_a.valid));
        check("reset rsp_b valid", 64'(1'b0), 64'(rsp_b.valid));
        check("reset arvalid", 64'(1'b0), 64'(ar.arvalid));
        check("reset rready", 64'(1'b0), 64'(rready));
    endtask

    initial begin
        void'($urandom(88));
        reset = 1'b0;
        req_a = '0;
        req_b = '0;
        reset_model();
        repeat (10) @(negedge clk);
        check_reset_values();
        reset = 1'b1;
        @(negedge clk);
        check_reset_values();
        fork
            drive_port(0);
            drive_port(1);
        join
        while (resp_count < 2 * num_reqs) @(negedge clk);
        repeat (5) @(negedge clk);   // room for a stray extra response
        if ((resp_count == 2 * num_reqs) && (exp_a.size() == 0) && (exp_b.size() == 0)) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("response count is %0d, not %0d", resp_count, 2 * num_reqs);
            fail_run();
        end
    end

endmodule

`default_nettype wire

// ==== bench/axi_lite_rom.sv ====
`default_nettype none

module axi_lite_rom
    import icache_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire axi_ar_t ar,
    output logic         arready,
    output axi_r_t       r,
    input  wire logic    rready
);

    localparam axi_resp_t resp_slverr = 2'b10;

    typedef enum logic [2:0] {
        rom_idle,
        rom_ar_wait,
        rom_ar_done,
        rom_r_wait,
        rom_r_hold
    } rom_state_t;

    rom_state_t  state;
    int unsigned delay;      // cycles left before ready or valid
    int unsigned pick;
    addr_t       addr_q;
    logic        r_taken;    // R handshake at the last rising edge

    // word at A is A with its halves swapped, bit 31 marks a bad address
    function automatic axi_r_t answer(input addr_t a);
        axi_r_t beat;
        beat.rvalid = 1'b1;
        beat.rdata  = {a[15:0], a[31:16]};
        beat.rresp  = a[31] ? resp_slverr : axi_okay;
        return beat;
    endfunction

    always @(posedge clk) begin
        r_taken <= r.rvalid && rready;
    end

    // outputs only move on the falling edge
    initial begin
        arready = 1'b0;
        r       = '0;
        state   = rom_idle;
        delay   = 0;
        forever begin
            @(negedge clk);
            if (!reset) begin
                arready = 1'b0;
                r       = '0;
                state   = rom_idle;
            end else begin
                case (state)
                    rom_idle: begin
                        if (ar.arvalid) begin
                            pick = $urandom % 5;
                            delay = pick;
                            state = rom_ar_wait;
                        end
                    end
                    rom_ar_wait: begin
                        if (delay == 0) begin
                            arready = 1'b1;
                            addr_q  = ar.araddr;   // arvalid holds it until the edge
                            state   = rom_ar_done;
                        end else begin
                            delay = delay - 1;
                        end
                    end
                    rom_ar_done: begin
                        arready = 1'b0;
                        pick    = $urandom % 5;
                        delay   = pick;
                        state   = rom_r_wait;
                    end
                    rom_r_wait: begin
                        if (delay == 0) begin
                            r     = answer(addr_q);
                            state = rom_r_hold;
                        end else begin
                            delay = delay - 1;
                        end
                    end
                    default: begin
                        if (r_taken) begin
                            r     = '0;
                            state = rom_idle;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_pair_top.sv ====
`default_nettype none

module icache_pair_top
    import icache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire fetch_req_t req_a,
    output logic            req_ready_a,
    output fetch_rsp_t      rsp_a,
    input  wire fetch_req_t req_b,
    output logic            req_ready_b,
    output fetch_rsp_t      rsp_b,
    output axi_ar_t         ar,
    input  wire logic       arready,
    input  wire axi_r_t     r,
    output logic            rready
);

    fill_req_t fill_req_a;
    fill_req_t fill_req_b;
    fill_rsp_t fill_rsp_a;
    fill_rsp_t fill_rsp_b;

    icache cache_a (
        .clk       (clk),
        .reset     (reset),
        .req       (req_a),
        .req_ready (req_ready_a),
        .rsp       (rsp_a),
        .fill_req  (fill_req_a),
        .fill_rsp  (fill_rsp_a)
    );

    icache cache_b (
        .clk       (clk),
        .reset     (reset),
        .req       (req_b),
        .req_ready (req_ready_b),
        .rsp       (rsp_b),
        .fill_req  (fill_req_b),
        .fill_rsp  (fill_rsp_b)
    );

    // single memory port shared by both caches
    fill_arbiter fill_arbiter_i (
        .clk        (clk),
        .reset      (reset),
        .fill_req_a (fill_req_a),
        .fill_req_b (fill_req_b),
        .fill_rsp_a (fill_rsp_a),
        .fill_rsp_b (fill_rsp_b),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .rready     (rready)
    );

endmodule

`default_nettype wire

// ==== src/fill_arbiter.sv ====
`default_nettype none

module fill_arbiter
    import icache_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire fill_req_t fill_req_a,
    input  wire fill_req_t fill_req_b,
    output fill_rsp_t      fill_rsp_a,
    output fill_rsp_t      fill_rsp_b,
    output axi_ar_t        ar,
    input  wire logic      arready,
    input  wire axi_r_t    r,
    output logic           rready
);

    arb_state_t state_q;

    logic  last_b_q;         // round-robin pointer, b was served last
    logic  grant_b_q;        // owner of the read in flight
    addr_t araddr_q;

    logic  req_a_live;
    logic  req_b_live;
    logic  pick_b;
    logic  r_fire;

    logic  rsp_valid_a_q;
    logic  rsp_valid_b_q;
    word_t rsp_data_q;
    logic  rsp_err_q;

    // a request still up during its own response pulse is already served
    assign req_a_live = fill_req_a.valid && !fill_rsp_a.valid;
    assign req_b_live = fill_req_b.valid && !fill_rsp_b.valid;
    assign pick_b     = req_b_live && (!req_a_live || !last_b_q);

    assign rready = (state_q == arb_data);
    assign r_fire = r.rvalid && rready;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q   <= arb_idle;
            last_b_q  <= 1'b1;     // first tie goes to a
            grant_b_q <= 1'b0;
        end else begin
            case (state_q)
                arb_idle: begin
                    if (req_a_live || req_b_live) begin
                        state_q   <= arb_addr;
                        grant_b_q <= pick_b;
                        last_b_q  <= pick_b;
                    end
                end
                arb_addr: begin
                    if (arready) begin
                        state_q <= arb_data;
                    end
                end
                arb_data: begin
                    if (r.rvalid) begin
                        state_q <= arb_idle;
                    end
                end
                default: state_q <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == arb_idle) && (req_a_live || req_b_live)) begin
            araddr_q <= pick_b ? fill_req_b.addr : fill_req_a.addr;
        end
        if (r_fire) begin
            rsp_data_q <= r.rdata;
            rsp_err_q  <= (r.rresp != axi_okay);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rsp_valid_a_q <= 1'b0;
            rsp_valid_b_q <= 1'b0;
        end else begin
            rsp_valid_a_q <= r_fire && !grant_b_q;
            rsp_valid_b_q <= r_fire && grant_b_q;
        end
    end

    assign ar.arvalid = (state_q == arb_addr);
    assign ar.araddr  = araddr_q;

    assign fill_rsp_a = '{valid: rsp_valid_a_q, data: rsp_data_q, err: rsp_err_q};
    assign fill_rsp_b = '{valid: rsp_valid_b_q, data: rsp_data_q, err: rsp_err_q};

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`default_nettype none
`include "icache_defines.svh"

module icache
    import icache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire fetch_req_t req,
    output logic            req_ready,
    output fetch_rsp_t      rsp,
    output fill_req_t       fill_req,
    input  wire fill_rsp_t  fill_rsp
);

    localparam age_t age_oldest = age_t'(`ICACHE_WAYS - 1);

    cache_state_t state_q;

    // storage, valid and age are control state
    tag_t  tag_mem   [`ICACHE_WAYS][`ICACHE_SETS];
    word_t data_mem  [`ICACHE_WAYS][`ICACHE_SETS];
    logic  valid_q   [`ICACHE_WAYS][`ICACHE_SETS];
    age_t  age_q     [`ICACHE_WAYS][`ICACHE_SETS];

    addr_t  addr_q;          // request address, held until the response
    tag_t   tag;
    index_t index;

    logic [`ICACHE_WAYS-1:0] way_hit;
    logic   hit;
    way_t   hit_way;
    word_t  hit_data;
    way_t   victim;
    way_t   victim_q;        // picked in miss, written in fill

    logic   req_fire;
    logic   fill_done;       // fill response seen this cycle
    logic   fill_ok;         // fill without error, line gets allocated
    logic   lookup_hit;
    logic   touch;           // ages move this cycle
    way_t   use_way;
    age_t   use_age;

    logic   rsp_valid_q;
    word_t  rsp_data_q;
    logic   rsp_hit_q;
    logic   rsp_err_q;

    assign tag   = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign index = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    assign req_ready = (state_q == cache_idle);
    assign req_fire  = req.valid && req_ready;

    assign lookup_hit = (state_q == cache_lookup) && hit;
    assign fill_done  = (state_q == cache_fill) && fill_rsp.valid;
    assign fill_ok    = fill_done && !fill_rsp.err;

    // tag compare over the four ways
    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (valid_q[w][index] && (tag_mem[w][index] == tag)) begin
                way_hit[w] = 1'b1;
                hit_way    = way_t'(w);
            end
        end
    end

    assign hit      = |way_hit;
    assign hit_data = data_mem[hit_way][index];

    // victim: lowest invalid way, else the oldest one
    always_comb begin
        victim = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (age_q[w][index] == age_oldest) begin
                victim = way_t'(w);
            end
        end
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w][index]) begin
                victim = way_t'(w);  // last write wins, so lowest index
            end
        end
    end

    assign touch   = lookup_hit || fill_ok;
    assign use_way = (state_q == cache_fill) ? victim_q : hit_way;
    assign use_age = age_q[use_way][index];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q <= cache_idle;
        end else begin
            case (state_q)
                cache_idle: begin
                    if (req_fire) begin
                        state_q <= cache_lookup;
                    end
                end
                cache_lookup: begin
                    state_q <= hit ? cache_idle : cache_miss;
                end
                cache_miss: begin
                    state_q <= cache_fill;   // fill request goes out next
                end
                cache_fill: begin
                    if (fill_rsp.valid) begin
                        state_q <= cache_idle;
                    end
                end
                default: state_q <= cache_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= req.addr;
        end
        if (state_q == cache_miss) begin
            victim_q <= victim;
        end
    end

    // valid bits and LRU ages
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                    age_q[w][s]   <= age_t'(w);  // distinct ages 0..3
                end
            end
        end else begin
            if (fill_ok) begin
                valid_q[victim_q][index] <= 1'b1;
            end
            if (touch) begin
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    if (way_t'(w) == use_way) begin
                        age_q[w][index] <= '0;
                    end else if (age_q[w][index] < use_age) begin
                        age_q[w][index] <= age_q[w][index] + age_t'(1);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_ok) begin
            tag_mem[victim_q][index]  <= tag;
            data_mem[victim_q][index] <= fill_rsp.data;
        end
    end

    // one response per accepted request
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= lookup_hit || fill_done;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == cache_lookup) begin
            rsp_data_q <= hit_data;
            rsp_hit_q  <= hit;
            rsp_err_q  <= 1'b0;
        end else if (fill_done) begin
            rsp_data_q <= fill_rsp.data;  // passed on even when err is set
            rsp_hit_q  <= 1'b0;
            rsp_err_q  <= fill_rsp.err;
        end
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.data  = rsp_data_q;
    assign rsp.hit   = rsp_hit_q;
    assign rsp.err   = rsp_err_q;

    assign fill_req.valid = (state_q == cache_fill);
    assign fill_req.addr  = {tag, index, {`ICACHE_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none
`include "icache_defines.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]        addr_t;
    typedef logic [`ICACHE_WORD_W-1:0]        word_t;
    typedef logic [`ICACHE_TAG_W-1:0]         tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]       index_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0]  way_t;
    typedef logic [$clog2(`ICACHE_WAYS)-1:0]  age_t;   // 0 is most recent
    typedef logic [1:0]                       axi_resp_t;

    localparam axi_resp_t axi_okay = 2'b00;

    typedef enum logic [1:0] {
        cache_idle,
        cache_lookup,
        cache_miss,
        cache_fill
    } cache_state_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_addr,
        arb_data
    } arb_state_t;

    typedef struct packed {logic valid; addr_t addr;} fetch_req_t;
    typedef struct packed {logic valid; word_t data; logic hit; logic err;} fetch_rsp_t;
    typedef struct packed {logic valid; addr_t addr;} fill_req_t;
    typedef struct packed {logic valid; word_t data; logic err;} fill_rsp_t;
    typedef struct packed {logic arvalid; addr_t araddr;} axi_ar_t;
    typedef struct packed {logic rvalid; word_t rdata; axi_resp_t rresp;} axi_r_t;

endpackage

`default_nettype wire

// ==== src/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// address and instruction word
`define ICACHE_ADDR_W   32
`define ICACHE_WORD_W   32

// geometry of one cache
`define ICACHE_SETS     64
`define ICACHE_WAYS     4

// address split, one word per line
`define ICACHE_OFFSET_W 2
`define ICACHE_INDEX_W  6
`define ICACHE_TAG_W    (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

`endif
